/* Makefile */
# Verilator build and run for the TCDM request equalizer.

VERILATOR ?= verilator
FLAGS     ?= --binary --timing
TOP       ?= tb_tcdm_equalizer
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: compile
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then echo "Simulation reported failure"; exit 1; fi
	@if ! grep -q "TEST PASSED" $(LOG); then echo "Simulation ended without a result"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* common/tcdm_if.sv */
/*
 * One TCDM channel: request/grant handshake with a response one
 * cycle after the transfer. wen high is a read, low is a write.
 * Used as arrays of NB_CHAN between the pipeline stages.
 */

`timescale 1ns/100ps
`default_nettype none

interface tcdm_if import tcdm_pkg::*; ();

  logic              req;      // Request, held until gnt.
  logic [ADDR_W-1:0] add;      // Byte address.
  logic              wen;      // High for read.
  logic [BE_W-1:0]   be;
  logic [DATA_W-1:0] data;     // Write data.
  logic              gnt;      // Transfer in this cycle.
  logic [DATA_W-1:0] r_data;
  logic              r_valid;  // One cycle after the transfer.

  // Requester side.
  modport master (
    output req, add, wen, be, data,
    input  gnt, r_data, r_valid
  );

  // Memory side.
  modport slave (
    input  req, add, wen, be, data,
    output gnt, r_data, r_valid
  );

endinterface

`default_nettype wire

/* common/tcdm_pkg.sv */
/*
 * Shared widths, counts and types for the TCDM request equalizer.
 * Every RTL module imports this package in its header, and the
 * testbench uses the same constants for its reference model.
 */

`default_nettype none

package tcdm_pkg;

  // ====================================================================
  // Channel and bank counts
  // ====================================================================
  localparam int unsigned NB_CHAN  = 4;                 // Request channels.
  localparam int unsigned NB_BANKS = 4;                 // Interleaved banks.
  localparam int unsigned ORDER_W  = $clog2(NB_CHAN);   // Rotation amount.
  localparam int unsigned BANK_W   = $clog2(NB_BANKS);  // Bank index.

  // ====================================================================
  // Bus widths
  // ====================================================================
  localparam int unsigned ADDR_W = 32;        // Byte address.
  localparam int unsigned DATA_W = 32;
  localparam int unsigned BE_W   = DATA_W / 8; // One enable per byte.

  // Word-interleaved geometry.
  // Bank index sits just above the byte offset, row just above that.
  localparam int unsigned BANK_SEL_LSB = 2;
  localparam int unsigned BANK_WORDS   = 64;
  localparam int unsigned ROW_W        = $clog2(BANK_WORDS);
  localparam int unsigned ROW_LSB      = BANK_SEL_LSB + BANK_W;

  // Order source for the reorder stage.
  typedef enum logic {
    ORDER_FIXED  = 1'b0,  // External order value.
    ORDER_ROTATE = 1'b1   // Advance by one each cycle.
  } order_mode_e;

endpackage

`default_nettype wire

/* filelist.f */
common/tcdm_pkg.sv
common/tcdm_if.sv
src/order_sequencer.sv
src/tcdm_reorder.sv
tcdm_mem/tcdm_bank_xbar.sv
tcdm_mem/tcdm_bank.sv
src/tcdm_equalizer_top.sv
testbench/tb_clkgen.sv
testbench/tb_tcdm_equalizer.sv

/* src/order_sequencer.sv */
/*
 * Rotation amount for the reorder stage.
 * Fixed mode loads the external value, rotate mode counts up by one
 * per cycle. The output is registered, so it is stable within a cycle.
 */

`timescale 1ns/100ps
`default_nettype none

module order_sequencer import tcdm_pkg::*; (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic               clear_i,
  input  order_mode_e        order_mode,
  input  logic [ORDER_W-1:0] order_value,
  output logic [ORDER_W-1:0] order
);

  logic [ORDER_W-1:0] order_d;

  // Next order.
  always_comb begin : order_next_comb
    if (clear_i) begin
      order_d = '0;                       // Restart from channel 0.
    end else if (order_mode == ORDER_FIXED) begin
      order_d = order_value;
    end else begin
      order_d = order + ORDER_W'(1);      // Wraps modulo NB_CHAN.
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin : order_reg
    if (!rst_ni) begin
      order <= '0;
    end else begin
      order <= order_d;
    end
  end

endmodule

`default_nettype wire

/* src/tcdm_equalizer_top.sv */
/*
 * TCDM request equalizer: order sequencer, channel reorder, bank
 * crossbar and NB_BANKS memory banks. Plain per-channel ports are
 * packed into interface arrays between the stages.
 */

`timescale 1ns/100ps
`default_nettype none

module tcdm_equalizer_top import tcdm_pkg::*; (
  input  logic                            clk_i,
  input  logic                            rst_ni,
  input  logic                            clear_i,
  input  order_mode_e                     order_mode,
  input  logic [ORDER_W-1:0]              order_value,
  input  logic [NB_CHAN-1:0]              req,
  input  logic [NB_CHAN-1:0][ADDR_W-1:0]  add,
  input  logic [NB_CHAN-1:0]              wen,
  input  logic [NB_CHAN-1:0][BE_W-1:0]    be,
  input  logic [NB_CHAN-1:0][DATA_W-1:0]  data,
  output logic [NB_CHAN-1:0]              gnt,
  output logic [NB_CHAN-1:0][DATA_W-1:0]  r_data,
  output logic [NB_CHAN-1:0]              r_valid
);

  logic [ORDER_W-1:0] order;

  logic [NB_BANKS-1:0]             bank_req;
  logic [NB_BANKS-1:0]             bank_wen;
  logic [NB_BANKS-1:0][ROW_W-1:0]  bank_row;
  logic [NB_BANKS-1:0][BE_W-1:0]   bank_be;
  logic [NB_BANKS-1:0][DATA_W-1:0] bank_wdata;
  logic [NB_BANKS-1:0][DATA_W-1:0] bank_rdata;

  tcdm_if in_chan  [NB_CHAN] ();  // Ports to reorder.
  tcdm_if out_chan [NB_CHAN] ();  // Reorder to crossbar.

  // ====================================================================
  // Port packing
  // ====================================================================
  for (genvar i = 0; i < NB_CHAN; i++) begin : g_port
    assign in_chan[i].req  = req[i];
    assign in_chan[i].add  = add[i];
    assign in_chan[i].wen  = wen[i];
    assign in_chan[i].be   = be[i];
    assign in_chan[i].data = data[i];
    assign gnt[i]          = in_chan[i].gnt;
    assign r_data[i]       = in_chan[i].r_data;
    assign r_valid[i]      = in_chan[i].r_valid;
  end

  // ====================================================================
  // Pipeline stages
  // ====================================================================
  order_sequencer order_sequencer_inst (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .clear_i     (clear_i),
    .order_mode  (order_mode),
    .order_value (order_value),
    .order       (order)
  );

  tcdm_reorder tcdm_reorder_inst (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .clear_i (clear_i),
    .order   (order),
    .in      (in_chan),
    .out     (out_chan)
  );

  tcdm_bank_xbar tcdm_bank_xbar_inst (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .chan       (out_chan),
    .bank_req   (bank_req),
    .bank_wen   (bank_wen),
    .bank_row   (bank_row),
    .bank_be    (bank_be),
    .bank_wdata (bank_wdata),
    .bank_rdata (bank_rdata)
  );

  // One bank per interleave slot.
  for (genvar b = 0; b < NB_BANKS; b++) begin : g_bank
    tcdm_bank tcdm_bank_inst (
      .clk_i (clk_i),
      .req   (bank_req[b]),
      .wen   (bank_wen[b]),
      .row   (bank_row[b]),
      .be    (bank_be[b]),
      .wdata (bank_wdata[b]),
      .rdata (bank_rdata[b])
    );
  end

endmodule

`default_nettype wire

/* src/tcdm_reorder.sv */
/*
 * Rotates NB_CHAN TCDM channels by the current order.
 * Output j carries input (order + j) mod NB_CHAN. Requests and grants
 * pass combinationally, responses follow last cycle's mapping.
 */

`timescale 1ns/100ps
`default_nettype none

module tcdm_reorder import tcdm_pkg::*; (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic               clear_i,
  input  logic [ORDER_W-1:0] order,
  tcdm_if.slave              in  [NB_CHAN],
  tcdm_if.master             out [NB_CHAN]
);

  logic [NB_CHAN-1:0][ORDER_W-1:0] winner;    // Input feeding each output.
  logic [NB_CHAN-1:0][ORDER_W-1:0] winner_q;  // Mapping of the last cycle.

  // Flattened channel signals.
  logic [NB_CHAN-1:0]             in_req;
  logic [NB_CHAN-1:0][ADDR_W-1:0] in_add;
  logic [NB_CHAN-1:0]             in_wen;
  logic [NB_CHAN-1:0][BE_W-1:0]   in_be;
  logic [NB_CHAN-1:0][DATA_W-1:0] in_data;
  logic [NB_CHAN-1:0]             in_gnt;
  logic [NB_CHAN-1:0][DATA_W-1:0] in_r_data;
  logic [NB_CHAN-1:0]             in_r_valid;
  logic [NB_CHAN-1:0]             out_gnt;
  logic [NB_CHAN-1:0][DATA_W-1:0] out_r_data;
  logic [NB_CHAN-1:0]             out_r_valid;

  // ====================================================================
  // Request path
  // ====================================================================
  always_comb begin : winner_comb
    for (int j = 0; j < NB_CHAN; j++) begin
      winner[j] = order + ORDER_W'(j);  // Modulo by truncation.
    end
  end

  for (genvar j = 0; j < NB_CHAN; j++) begin : g_chan
    assign in_req[j]  = in[j].req;
    assign in_add[j]  = in[j].add;
    assign in_wen[j]  = in[j].wen;
    assign in_be[j]   = in[j].be;
    assign in_data[j] = in[j].data;

    // Steer the winning input onto output j.
    assign out[j].req  = in_req[winner[j]];
    assign out[j].add  = in_add[winner[j]];
    assign out[j].wen  = in_wen[winner[j]];
    assign out[j].be   = in_be[winner[j]];
    assign out[j].data = in_data[winner[j]];

    assign out_gnt[j]     = out[j].gnt;
    assign out_r_data[j]  = out[j].r_data;
    assign out_r_valid[j] = out[j].r_valid;

    assign in[j].gnt     = in_gnt[j];
    assign in[j].r_data  = in_r_data[j];
    assign in[j].r_valid = in_r_valid[j];
  end

  // ====================================================================
  // Response path
  // ====================================================================
  // Identity mapping out of reset, same as order 0.
  always_ff @(posedge clk_i or negedge rst_ni) begin : winner_reg
    if (!rst_ni) begin
      for (int j = 0; j < NB_CHAN; j++) winner_q[j] <= ORDER_W'(j);
    end else if (clear_i) begin
      for (int j = 0; j < NB_CHAN; j++) winner_q[j] <= ORDER_W'(j);
    end else begin
      winner_q <= winner;
    end
  end

  // Mapping is a permutation, so each input gets exactly one output.
  always_comb begin : resp_comb
    in_gnt     = '0;
    in_r_data  = '0;
    in_r_valid = '0;
    for (int j = 0; j < NB_CHAN; j++) begin
      in_gnt[winner[j]]       = out_gnt[j];      // Same cycle.
      in_r_data[winner_q[j]]  = out_r_data[j];   // One cycle later.
      in_r_valid[winner_q[j]] = out_r_valid[j];
    end
  end

endmodule

`default_nettype wire

/* tcdm_mem/tcdm_bank.sv */
/*
 * Single TCDM bank of BANK_WORDS words.
 * Writes update the enabled bytes, reads return the word one cycle
 * later. A read sees the contents from before the clock edge.
 */

`timescale 1ns/100ps
`default_nettype none

module tcdm_bank import tcdm_pkg::*; (
  input  logic              clk_i,
  input  logic              req,
  input  logic              wen,    // High for read.
  input  logic [ROW_W-1:0]  row,
  input  logic [BE_W-1:0]   be,
  input  logic [DATA_W-1:0] wdata,
  output logic [DATA_W-1:0] rdata
);

  logic [DATA_W-1:0] mem_q [BANK_WORDS];  // Storage array.

  // Byte-enabled write.
  always_ff @(posedge clk_i) begin : write_proc
    if (req && !wen) begin
      for (int i = 0; i < BE_W; i++) begin
        if (be[i]) begin
          mem_q[row][8*i +: 8] <= wdata[8*i +: 8];
        end
      end
    end
  end

  // Registered read, holds its value otherwise.
  always_ff @(posedge clk_i) begin : read_proc
    if (req && wen) begin
      rdata <= mem_q[row];
    end
  end

endmodule

`default_nettype wire

/* tcdm_mem/tcdm_bank_xbar.sv */
/*
 * Crossbar from NB_CHAN TCDM channels to NB_BANKS memory banks.
 * Each bank grants its lowest-indexed requester in the same cycle.
 * Read data returns one cycle later to the channel that was granted.
 */

`timescale 1ns/100ps
`default_nettype none

module tcdm_bank_xbar import tcdm_pkg::*; (
  input  logic                             clk_i,
  input  logic                             rst_ni,
  tcdm_if.slave                            chan [NB_CHAN],
  output logic [NB_BANKS-1:0]              bank_req,
  output logic [NB_BANKS-1:0]              bank_wen,
  output logic [NB_BANKS-1:0][ROW_W-1:0]   bank_row,
  output logic [NB_BANKS-1:0][BE_W-1:0]    bank_be,
  output logic [NB_BANKS-1:0][DATA_W-1:0]  bank_wdata,
  input  logic [NB_BANKS-1:0][DATA_W-1:0]  bank_rdata
);

  // Decoded channel requests.
  logic [NB_CHAN-1:0]             chan_req;
  logic [NB_CHAN-1:0]             chan_wen;
  logic [NB_CHAN-1:0][BANK_W-1:0] chan_bank;
  logic [NB_CHAN-1:0][ROW_W-1:0]  chan_row;
  logic [NB_CHAN-1:0][BE_W-1:0]   chan_be;
  logic [NB_CHAN-1:0][DATA_W-1:0] chan_wdata;
  logic [NB_CHAN-1:0]             chan_gnt;

  logic [NB_BANKS-1:0][ORDER_W-1:0] bank_win;  // Winning channel per bank.
  logic [NB_CHAN-1:0]               gnt_q;     // Granted last cycle.
  logic [NB_CHAN-1:0][BANK_W-1:0]   bank_q;    // Bank served last cycle.

  // ====================================================================
  // Address decode
  // ====================================================================
  for (genvar c = 0; c < NB_CHAN; c++) begin : g_dec
    assign chan_req[c]   = chan[c].req;
    assign chan_wen[c]   = chan[c].wen;
    assign chan_bank[c]  = chan[c].add[BANK_SEL_LSB +: BANK_W];
    assign chan_row[c]   = chan[c].add[ROW_LSB +: ROW_W];
    assign chan_be[c]    = chan[c].be;
    assign chan_wdata[c] = chan[c].data;

    assign chan[c].gnt     = chan_gnt[c];
    assign chan[c].r_valid = gnt_q[c];               // Writes answer too.
    assign chan[c].r_data  = bank_rdata[bank_q[c]];
  end

  // ====================================================================
  // Fixed-priority arbitration
  // ====================================================================
  always_comb begin : arb_comb
    chan_gnt = '0;
    bank_req = '0;
    bank_win = '0;
    for (int b = 0; b < NB_BANKS; b++) begin
      for (int c = 0; c < NB_CHAN; c++) begin
        // First hit wins, later channels wait.
        if (!bank_req[b] && chan_req[c] && (chan_bank[c] == BANK_W'(b))) begin
          bank_req[b] = 1'b1;
          bank_win[b] = ORDER_W'(c);
          chan_gnt[c] = 1'b1;
        end
      end
    end
  end

  // Winner payload to each bank.
  always_comb begin : steer_comb
    for (int b = 0; b < NB_BANKS; b++) begin
      bank_wen[b]   = chan_wen[bank_win[b]];
      bank_row[b]   = chan_row[bank_win[b]];
      bank_be[b]    = chan_be[bank_win[b]];
      bank_wdata[b] = chan_wdata[bank_win[b]];
    end
  end

  // Response bookkeeping, matches the one-cycle bank read.
  always_ff @(posedge clk_i or negedge rst_ni) begin : resp_reg
    if (!rst_ni) begin
      gnt_q  <= '0;
      bank_q <= '0;
    end else begin
      gnt_q  <= chan_gnt;
      bank_q <= chan_bank;
    end
  end

endmodule

`default_nettype wire

/* testbench/tb_clkgen.sv */
/*
 * Testbench clock and reset source.
 * 20 ns clock, active-low reset held for 10 cycles and
 * released on a falling edge.
 */

`timescale 1ns/100ps
`default_nettype none

module tb_clkgen (
  output logic clk,
  output logic rst_n
);

  localparam int unsigned PERIOD_NS    = 20;
  localparam int unsigned RESET_CYCLES = 10;

  initial begin : clk_proc
    clk = 1'b0;
    forever #(PERIOD_NS / 2) clk = ~clk;  // Free running.
  end

  initial begin : rst_proc
    rst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;  // Away from the active edge.
  end

endmodule

`default_nettype wire

/* testbench/tb_tcdm_equalizer.sv */
/*
 * Directed testbench for the TCDM request equalizer.
 * Inputs change on the falling edge, outputs are sampled a quarter
 * period later. Grants follow the channel rotation rules and read data
 * comes from a byte-level reference memory.
 */

`timescale 1ns/100ps
`default_nettype none

module tb_tcdm_equalizer import tcdm_pkg::*; ();

  // ====================================================================
  // Run length and timing
  // ====================================================================
  localparam int unsigned CLK_PERIOD_NS = 20;
  localparam int unsigned SETTLE_NS     = CLK_PERIOD_NS / 4;
  localparam int unsigned SEED          = 44;
  localparam int unsigned FAIR_ROUNDS   = 3;   // Grants per channel in rotate test.
  localparam int unsigned MIXED_CYCLES  = 24;
  localparam int unsigned TEST_CYCLES   = 10 + 12 + 10 + (4 * 12 + 8)
                                          + (4 * FAIR_ROUNDS + 8) + (MIXED_CYCLES + 22);
  localparam int unsigned MARGIN_CYCLES = 50;
  localparam int unsigned WATCHDOG_NS   = (TEST_CYCLES + MARGIN_CYCLES) * CLK_PERIOD_NS;
  localparam int unsigned MEM_BYTES     = NB_BANKS * BANK_WORDS * BE_W;
  localparam int unsigned MEM_AW        = $clog2(MEM_BYTES);

  logic                           clk_i;
  logic                           rst_ni;
  logic                           clear_i;
  order_mode_e                    order_mode;
  logic [ORDER_W-1:0]             order_value;
  logic [NB_CHAN-1:0]             req;
  logic [NB_CHAN-1:0][ADDR_W-1:0] add;
  logic [NB_CHAN-1:0]             wen;
  logic [NB_CHAN-1:0][BE_W-1:0]   be;
  logic [NB_CHAN-1:0][DATA_W-1:0] data;
  logic [NB_CHAN-1:0]             gnt;
  logic [NB_CHAN-1:0][DATA_W-1:0] r_data;
  logic [NB_CHAN-1:0]             r_valid;

  // Reference state.
  logic [7:0]                     ref_mem [MEM_BYTES];  // Byte image of all banks.
  logic [ORDER_W-1:0]             model_order;          // Order seen in this cycle.
  logic [NB_CHAN-1:0]             resp_pend;            // Response due this cycle.
  logic [NB_CHAN-1:0]             resp_read;
  logic [NB_CHAN-1:0][DATA_W-1:0] resp_data;
  logic [NB_CHAN-1:0]             dut_gnt;              // Grants sampled last cycle.
  int unsigned                    err_count;
  int unsigned                    check_count;

  tb_clkgen tb_clkgen_inst (
    .clk   (clk_i),
    .rst_n (rst_ni)
  );

  tcdm_equalizer_top tcdm_equalizer_top_inst (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .clear_i     (clear_i),
    .order_mode  (order_mode),
    .order_value (order_value),
    .req         (req),
    .add         (add),
    .wen         (wen),
    .be          (be),
    .data        (data),
    .gnt         (gnt),
    .r_data      (r_data),
    .r_valid     (r_valid)
  );

  // ====================================================================
  // Reference model and checks
  // ====================================================================
  task automatic check_value(input string name, input logic [DATA_W-1:0] expected,
                             input logic [DATA_W-1:0] actual);
    check_count++;
    if (actual !== expected) begin
      $display("ERROR %s: expected %h actual %h at %0t ns", name, expected, actual, $time);
      err_count++;
    end
  endtask

  function automatic logic [DATA_W-1:0] ref_read(input logic [ADDR_W-1:0] a);
    logic [DATA_W-1:0] w;
    int unsigned       base;
    base = int'(a[MEM_AW-1:BANK_SEL_LSB]) * BE_W;  // Word aligned.
    for (int i = 0; i < BE_W; i++) w[8*i +: 8] = ref_mem[base + i];
    return w;
  endfunction

  task automatic ref_write(input logic [ADDR_W-1:0] a, input logic [BE_W-1:0] byte_en,
                           input logic [DATA_W-1:0] wdata);
    int unsigned base;
    base = int'(a[MEM_AW-1:BANK_SEL_LSB]) * BE_W;
    for (int i = 0; i < BE_W; i++) begin
      if (byte_en[i]) ref_mem[base + i] = wdata[8*i +: 8];
    end
  endtask

  // Output j serves input (order + j) mod NB_CHAN, lowest output wins a bank.
  function automatic logic [NB_CHAN-1:0] expected_grants(input logic [ORDER_W-1:0] ord);
    logic [NB_CHAN-1:0]  g;
    logic [NB_BANKS-1:0] taken;
    int                  in_ch;
    int                  bk;
    g     = '0;
    taken = '0;
    for (int j = 0; j < NB_CHAN; j++) begin
      in_ch = (int'(ord) + j) % NB_CHAN;
      bk    = int'(add[in_ch][BANK_SEL_LSB +: BANK_W]);
      if (req[in_ch] && !taken[bk]) begin
        taken[bk] = 1'b1;
        g[in_ch]  = 1'b1;
      end
    end
    return g;
  endfunction

  task automatic set_request(input int c, input logic rd, input int bank, input int row,
                             input logic [BE_W-1:0] byte_en, input logic [DATA_W-1:0] wdata);
    req[c]  = 1'b1;
    wen[c]  = rd;                                        // High for read.
    add[c]  = ADDR_W'((row * NB_BANKS + bank) * BE_W);
    be[c]   = byte_en;
    data[c] = wdata;
  endtask

  // One clock cycle. Inputs are already driven at the falling edge.
  task automatic run_cycle(input string name);
    logic [NB_CHAN-1:0] exp_gnt;
    #(SETTLE_NS);
    exp_gnt = expected_grants(model_order);
    check_value({name, " gnt"}, DATA_W'(exp_gnt), DATA_W'(gnt));
    for (int c = 0; c < NB_CHAN; c++) begin
      if (resp_pend[c]) begin
        if (r_valid[c] !== 1'b1) begin
          $display("%s: channel %0d got no response one cycle after its grant", name, c);
          err_count++;
        end else if (resp_read[c]) begin
          check_value({name, " r_data"}, resp_data[c], r_data[c]);
        end
      end else begin
        check_value({name, " r_valid"}, DATA_W'(1'b0), DATA_W'(r_valid[c]));
      end
    end
    // Reads see memory from before this cycle's writes.
    for (int c = 0; c < NB_CHAN; c++) begin
      resp_pend[c] = exp_gnt[c];
      resp_read[c] = wen[c];
      if (exp_gnt[c] && wen[c]) resp_data[c] = ref_read(add[c]);
    end
    for (int c = 0; c < NB_CHAN; c++) begin
      if (exp_gnt[c] && !wen[c]) ref_write(add[c], be[c], data[c]);
    end
    dut_gnt = gnt;
    if (clear_i) model_order = '0;                          // Next cycle's order.
    else if (order_mode == ORDER_FIXED) model_order = order_value;
    else model_order = model_order + ORDER_W'(1);
    @(negedge clk_i);
    req = req & ~exp_gnt;                                   // Transfer done.
  endtask

  task automatic idle_cycles(input string name, input int n);
    req = '0;
    repeat (n) run_cycle(name);
  endtask

  // Runs until every held request is granted, then collects the responses.
  task automatic complete_requests(input string name, input int limit);
    int n;
    n = 0;
    while (req != '0 && n < limit) begin
      run_cycle(name);
      n++;
    end
    if (req != '0) begin
      $display("%s: requests on channels %b still waiting after %0d cycles", name, req, limit);
      err_count++;
      req = '0;
    end
    run_cycle(name);
  endtask

  // ====================================================================
  // Directed tests
  // ====================================================================
  task automatic test_fixed_distinct();
    string name;
    name        = "fixed_distinct";
    order_mode  = ORDER_FIXED;
    order_value = '0;
    idle_cycles(name, 1);
    for (int r = 0; r < 4; r++) begin                       // Channel c to bank c.
      for (int c = 0; c < NB_CHAN; c++) set_request(c, 1'b0, c, r, '1, $urandom());
      run_cycle(name);
    end
    for (int r = 0; r < 4; r++) begin
      for (int c = 0; c < NB_CHAN; c++) set_request(c, 1'b1, c, r, '1, '0);
      run_cycle(name);
    end
    complete_requests(name, 4);
  endtask

  task automatic test_partial_writes();
    string            name;
    logic [BE_W-1:0]  be_pat [4];
    name   = "partial_writes";
    be_pat = '{4'b0001, 4'b0110, 4'b1000, 4'b1011};
    for (int c = 0; c < NB_CHAN; c++) set_request(c, 1'b0, c, 8, '1, $urandom());
    run_cycle(name);
    for (int p = 0; p < 4; p++) begin
      for (int c = 0; c < NB_CHAN; c++) begin
        set_request(c, 1'b0, c, 8, be_pat[(p + c) % 4], $urandom());
      end
      run_cycle(name);
    end
    for (int c = 0; c < NB_CHAN; c++) set_request(c, 1'b1, c, 8, '1, '0);
    complete_requests(name, 4);
  endtask

  task automatic test_fixed_conflict();
    string name;
    name       = "fixed_conflict";
    order_mode = ORDER_FIXED;
    for (int k = 0; k < NB_CHAN; k++) begin
      order_value = ORDER_W'(k);
      idle_cycles(name, 1);                                 // Order settles to k.
      for (int t = 0; t < 4; t++) begin
        for (int c = 0; c < NB_CHAN; c++) begin
          if (!req[c]) set_request(c, 1'b0, 1, 16 + c, '1, $urandom());
        end
        run_cycle(name);
        check_value({name, " winner"}, DATA_W'(1) << k, DATA_W'(dut_gnt));
      end
      complete_requests(name, 8);                           // Losers drain in order.
    end
    for (int c = 0; c < NB_CHAN; c++) set_request(c, 1'b1, 1, 16 + c, '1, '0);
    complete_requests(name, 8);
  endtask

  task automatic test_rotate_fair();
    string name;
    int    grants [NB_CHAN];
    name       = "rotate_fair";
    order_mode = ORDER_ROTATE;
    idle_cycles(name, 2);                                   // Order moves off zero.
    clear_i    = 1'b1;
    idle_cycles(name, 1);
    clear_i    = 1'b0;
    for (int c = 0; c < NB_CHAN; c++) grants[c] = 0;
    for (int t = 0; t < 4 * FAIR_ROUNDS; t++) begin
      for (int c = 0; c < NB_CHAN; c++) begin
        if (!req[c]) set_request(c, 1'b0, 2, 24 + c, '1, $urandom());
      end
      run_cycle(name);
      if (t == 0) check_value({name, " first winner"}, DATA_W'(1), DATA_W'(dut_gnt));
      for (int c = 0; c < NB_CHAN; c++) grants[c] += int'(dut_gnt[c]);
    end
    complete_requests(name, 8);
    for (int c = 0; c < NB_CHAN; c++) begin
      check_value({name, " grant count"}, DATA_W'(FAIR_ROUNDS), DATA_W'(grants[c]));
    end
  endtask

  task automatic test_rotate_mixed();
    string name;
    name        = "rotate_mixed";
    order_mode  = ORDER_FIXED;
    order_value = '0;
    idle_cycles(name, 1);
    for (int r = 0; r < 8; r++) begin                       // Fill rows 32..39.
      for (int c = 0; c < NB_CHAN; c++) set_request(c, 1'b0, c, 32 + r, '1, $urandom());
      run_cycle(name);
    end
    complete_requests(name, 4);
    order_mode = ORDER_ROTATE;
    for (int t = 0; t < MIXED_CYCLES; t++) begin
      for (int c = 0; c < NB_CHAN; c++) begin
        if (!req[c]) begin
          set_request(c, 1'b1, int'($urandom() % NB_BANKS), 32 + int'($urandom() % 8), '1, '0);
        end
      end
      run_cycle(name);
    end
    complete_requests(name, 8);
  endtask

  // ====================================================================
  // Main sequence and watchdog
  // ====================================================================
  initial begin : main_proc
    void'($urandom(SEED));
    clear_i     = 1'b0;
    order_mode  = ORDER_FIXED;
    order_value = '0;
    req         = '0;
    add         = '0;
    wen         = '0;
    be          = '0;
    data        = '0;
    model_order = '0;                                       // Reset value.
    resp_pend   = '0;
    resp_read   = '0;
    resp_data   = '0;
    dut_gnt     = '0;
    err_count   = 0;
    check_count = 0;
    @(posedge rst_ni);                                      // Released on a falling edge.
    test_fixed_distinct();
    test_partial_writes();
    test_fixed_conflict();
    test_rotate_fair();
    test_rotate_mixed();
    $display("Checks: %0d, errors: %0d", check_count, err_count);
    if (err_count == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  initial begin : watchdog_proc
    #(WATCHDOG_NS);
    $display("Timeout: the tests did not finish within %0d ns", WATCHDOG_NS);
    $display("TEST FAILED");
    $finish;
  end

endmodule

`default_nettype wire
